/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mod_exp_997
FILELIST   := compile.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* bench/mod_exp_997_assert.sv */
`timescale 1ns/1ps

module mod_exp_997_assert (
  input logic                             clk,
  input logic                             rst,
  input logic                             wr_en,
  input logic [mod997_pkg::ADDR_BITS-1:0] wr_addr,
  input logic [mod997_pkg::RES_BITS-1:0]  wr_data,
  input logic [mod997_pkg::ADDR_BITS-1:0] rd_addr,
  input logic [mod997_pkg::RES_BITS-1:0]  rd_data,
  input logic                             done,
  input logic                             busy
);

  import mod997_pkg::*;

  // Shadow of the register file
  residue_t            base_ref;
  logic [EXP_BITS-1:0] exp_ref;
  residue_t            res_ref;
  logic                flag_ref;
  logic                start_ref;
  // Running job, power taken at the accepted start
  residue_t            job_res;
  logic                job_on;
  // Edges since the control write was sampled
  logic [3:0]          edge_cnt;
  logic                busy_exp;
  logic                done_exp;
  logic                wr_ctrl;
  residue_t            rd_exp;
  // One sticky flag per property
  bit                  fail_result = 1'b0;
  bit                  fail_read = 1'b0;
  bit                  fail_busy = 1'b0;
  bit                  fail_done = 1'b0;
  logic                any_fail;

  // Plain repeated multiplication, exponent 0 gives 1
  function automatic residue_t pow_ref(input int unsigned base, input int unsigned exponent);
    int unsigned acc;
    acc = 1;
    for (int unsigned i = 0; i < exponent; i++)
      acc = (acc * base) % MODULUS;
    return RES_BITS'(acc);
  endfunction

  assign wr_ctrl  = wr_en && (wr_addr == ADDR_CTRL);
  // Busy for edges 1 to 10, done on edge 11
  assign busy_exp = job_on && (edge_cnt >= 4'd1) && (edge_cnt <= 4'd10);
  assign done_exp = job_on && (edge_cnt == 4'd11);
  assign any_fail = fail_result | fail_read | fail_busy | fail_done;

  // *************************************************************************
  // Reference model
  // *************************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      base_ref  <= '0;
      exp_ref   <= '0;
      res_ref   <= '0;
      flag_ref  <= 1'b0;
      start_ref <= 1'b0;
      job_res   <= '0;
      job_on    <= 1'b0;
      edge_cnt  <= '0;
    end
    else
    begin
      // Start pulse trails the control write by one edge
      start_ref <= wr_ctrl;
      if (wr_en && (wr_addr == ADDR_BASE))
        base_ref <= RES_BITS'(wr_data % MODULUS);
      if (wr_en && (wr_addr == ADDR_EXP))
        exp_ref <= wr_data;
      // Starts that reach a busy engine are dropped
      if (start_ref && !busy_exp)
      begin
        job_on   <= 1'b1;
        edge_cnt <= 4'd1;
        job_res  <= pow_ref(32'(base_ref), 32'(exp_ref));
      end
      else if (done_exp)
        job_on <= 1'b0;
      else if (job_on)
        edge_cnt <= edge_cnt + 4'd1;
      if (done_exp)
        res_ref <= job_res;
      if (start_ref)
        flag_ref <= 1'b0;
      else if (done_exp)
        flag_ref <= 1'b1;
    end
  end

  // Expected read word per address
  always_comb
  begin
    case (rd_addr)
      ADDR_BASE: rd_exp = base_ref;
      ADDR_EXP:  rd_exp = exp_ref;
      ADDR_CTRL: rd_exp = {{(RES_BITS - 2){1'b0}}, flag_ref, busy_exp};
      default:   rd_exp = res_ref;
    endcase
  end

  // *************************************************************************
  // Properties
  // *************************************************************************
  a_result: assert property (@(posedge clk) disable iff (rst)
    (rd_addr == ADDR_RESULT) |-> (rd_data == rd_exp))
  else
  begin
    fail_result = 1'b1;
    $error("Mismatch result: got %h expected %h", $sampled(rd_data), $sampled(rd_exp));
  end

  a_readback: assert property (@(posedge clk) disable iff (rst)
    (rd_addr != ADDR_RESULT) |-> (rd_data == rd_exp))
  else
  begin
    fail_read = 1'b1;
    $error("Mismatch rd_data at address %h: got %h expected %h",
           $sampled(rd_addr), $sampled(rd_data), $sampled(rd_exp));
  end

  // Also covers busy low in the done cycle
  a_busy: assert property (@(posedge clk) disable iff (rst) busy == busy_exp)
  else
  begin
    fail_busy = 1'b1;
    $error("Mismatch busy: got %h expected %h", $sampled(busy), $sampled(busy_exp));
  end

  // Eleven edges after the write, one cycle wide
  a_done: assert property (@(posedge clk) disable iff (rst) done == done_exp)
  else
  begin
    fail_done = 1'b1;
    $error("Mismatch done: got %h expected %h", $sampled(done), $sampled(done_exp));
  end

endmodule

bind mod_exp_997_top mod_exp_997_assert u_checks (.*);

/* bench/tb_mod_exp_997.sv */
`timescale 1ns/1ps

module tb_mod_exp_997;

  import mod997_pkg::*;

  logic                 clk;
  logic                 rst;
  logic                 wr_en;
  logic [ADDR_BITS-1:0] wr_addr;
  logic [RES_BITS-1:0]  wr_data;
  logic [ADDR_BITS-1:0] rd_addr;
  logic [RES_BITS-1:0]  rd_data;
  logic                 done;
  logic                 busy;

  mod_exp_997_top u_mod_exp_997_top (.*);

  // 100 ns period
  always #50 clk = ~clk;

  // Stop at the first failing property
  always @(negedge clk)
  begin
    if (u_mod_exp_997_top.u_checks.any_fail)
    begin
      $display("TB FAILED");
      $fatal(1, "Checker property failed");
    end
  end

  // *************************************************************************
  // Register port tasks
  // *************************************************************************
  task automatic write_reg(input logic [ADDR_BITS-1:0] addr, input logic [RES_BITS-1:0] data);
    @(negedge clk);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  // Hold the address across one rising edge
  task automatic read_reg(input logic [ADDR_BITS-1:0] addr);
    @(negedge clk);
    rd_addr = addr;
    @(negedge clk);
  endtask

  task automatic wait_done();
    int unsigned cycles;
    cycles = 0;
    while (!done)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > 40)
      begin
        $display("TB FAILED");
        $fatal(1, "Timed out waiting for done");
      end
    end
  endtask

  task automatic run_job(input logic [RES_BITS-1:0] base, input logic [RES_BITS-1:0] exponent);
    write_reg(ADDR_BASE, base);
    write_reg(ADDR_EXP, exponent);
    read_reg(ADDR_BASE);
    read_reg(ADDR_EXP);
    // Status stays selected while the job runs
    rd_addr = ADDR_CTRL;
    write_reg(ADDR_CTRL, '0);
    wait_done();
    read_reg(ADDR_RESULT);
    read_reg(ADDR_CTRL);
  endtask

  // *************************************************************************
  // Stimulus
  // *************************************************************************
  initial
  begin
    clk     = 1'b0;
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_addr = '0;
    void'($urandom(32'h181b_1b03));
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // Edge values
    run_job(10'd123, 10'd0);
    run_job(10'd0, 10'd57);
    run_job(10'd1, 10'd1023);
    run_job(10'd996, 10'd2);
    // 998 reads back as 1
    run_job(10'd998, 10'd5);

    // New base and a second start mid-job are ignored
    rd_addr = ADDR_CTRL;
    write_reg(ADDR_BASE, 10'd5);
    write_reg(ADDR_EXP, 10'd300);
    write_reg(ADDR_CTRL, '0);
    write_reg(ADDR_BASE, 10'd7);
    write_reg(ADDR_CTRL, '0);
    wait_done();
    read_reg(ADDR_RESULT);

    // Random jobs, base may exceed the modulus
    repeat (24) run_job(RES_BITS'($urandom()), RES_BITS'($urandom()));

    @(negedge clk);
    if (u_mod_exp_997_top.u_checks.any_fail)
    begin
      $display("TB FAILED");
      $fatal(1, "Checker property failed");
    end
    else
    begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

/* compile.f */
source/mod997_pkg.sv
source/mod_mult_997.sv
source/mod_exp_engine.sv
source/exp_config_regs.sv
source/mod_exp_997_top.sv
bench/mod_exp_997_assert.sv
bench/tb_mod_exp_997.sv

/* source/exp_config_regs.sv */
`timescale 1ns/1ps

module exp_config_regs (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              wr_en,
  input  logic [mod997_pkg::ADDR_BITS-1:0]  wr_addr,
  input  logic [mod997_pkg::RES_BITS-1:0]   wr_data,
  input  logic [mod997_pkg::ADDR_BITS-1:0]  rd_addr,
  output logic [mod997_pkg::RES_BITS-1:0]   rd_data,
  input  mod997_pkg::exp_status_t           status,
  output mod997_pkg::exp_cfg_t              cfg,
  output logic                              start
);

  import mod997_pkg::*;

  // Written base brought below the modulus
  residue_t base_red;

  // Last finished power
  residue_t result_q;

  // Sticky completion flag
  logic     done_flag;

  // *************************************************************************
  // Write side
  // *************************************************************************
  // Only 997..1023 need fixing so one subtraction does it
  always_comb
  begin
    if (wr_data >= RES_BITS'(MODULUS))
    begin
      base_red = wr_data - RES_BITS'(MODULUS);
    end
    else
    begin
      base_red = wr_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cfg       <= '0;
      start     <= 1'b0;
      result_q  <= '0;
      done_flag <= 1'b0;
    end
    else
    begin
      // Any control write starts a job
      // Engine decides whether to take it
      start <= wr_en && (wr_addr == ADDR_CTRL);

      if (wr_en && (wr_addr == ADDR_BASE))
      begin
        cfg.base <= base_red;
      end
      if (wr_en && (wr_addr == ADDR_EXP))
      begin
        cfg.exponent <= wr_data;
      end

      // Start wins over a coincident done since the engine takes it
      if (start)
      begin
        done_flag <= 1'b0;
      end
      else if (status.done)
      begin
        done_flag <= 1'b1;
      end

      if (status.done)
      begin
        result_q <= status.result;
      end
    end
  end

  // *************************************************************************
  // Read side
  // *************************************************************************
  always_comb
  begin
    case (rd_addr)
      ADDR_BASE:   rd_data = cfg.base;
      ADDR_EXP:    rd_data = cfg.exponent;
      // Status word with busy in bit 0
      ADDR_CTRL:   rd_data = {{(RES_BITS - 2){1'b0}}, done_flag, status.busy};
      default:     rd_data = result_q;
    endcase
  end

endmodule

/* source/mod997_pkg.sv */
package mod997_pkg;

  // *************************************************************************
  // Field widths and the prime modulus
  // *************************************************************************
  localparam int unsigned MODULUS    = 997;
  localparam int unsigned RES_BITS   = 10;
  localparam int unsigned EXP_BITS   = 10;
  localparam int unsigned DIGIT_BITS = 3;
  localparam int unsigned ADDR_BITS  = 2;

  // Radix-8 digits per operand, top digit one bit wide
  localparam int unsigned NUM_DIGITS = (RES_BITS + DIGIT_BITS - 1) / DIGIT_BITS;
  // Iteration counter holds EXP_BITS down to 1
  localparam int unsigned ITER_BITS  = $clog2(EXP_BITS + 1);

  // Register map
  localparam logic [ADDR_BITS-1:0] ADDR_BASE   = 2'd0;
  localparam logic [ADDR_BITS-1:0] ADDR_EXP    = 2'd1;
  localparam logic [ADDR_BITS-1:0] ADDR_CTRL   = 2'd2;
  localparam logic [ADDR_BITS-1:0] ADDR_RESULT = 2'd3;

  // Residue below MODULUS
  typedef logic [RES_BITS-1:0] residue_t;

  // Job setup from register block to engine
  typedef struct packed {
    residue_t            base;
    logic [EXP_BITS-1:0] exponent;
  } exp_cfg_t;

  // Engine state back to register block
  typedef struct packed {
    logic     busy;
    logic     done;
    residue_t result;
  } exp_status_t;

  // *************************************************************************
  // Multiplier lookup tables
  // *************************************************************************
  // One table per digit weight 8^k for k = 0 .. 2*NUM_DIGITS-2
  localparam int unsigned PP_WEIGHTS = 2 * NUM_DIGITS - 1;
  // Indexed by the digit pair {da, db}
  localparam int unsigned PP_ENTRIES = 1 << (2 * DIGIT_BITS);
  // Sum of sixteen residues fits in 14 bits
  localparam int unsigned SUM_BITS   = 14;
  // Sum split points for the second fold
  localparam int unsigned FOLD_LO    = 6;
  localparam int unsigned FOLD_HI    = 10;
  localparam int unsigned FOLD_ENTRIES = 1 << (FOLD_HI - FOLD_LO);

  // Entry [k][{da, db}] holds da * db * 8^k mod MODULUS
  function automatic logic [PP_WEIGHTS-1:0][PP_ENTRIES-1:0][RES_BITS-1:0] build_pp_rom();
    logic [PP_WEIGHTS-1:0][PP_ENTRIES-1:0][RES_BITS-1:0] rom;
    int unsigned weight;
    weight = 1;
    for (int unsigned k = 0; k < PP_WEIGHTS; k++)
    begin
      for (int unsigned idx = 0; idx < PP_ENTRIES; idx++)
      begin
        rom[k][idx] = RES_BITS'(((idx >> DIGIT_BITS) * (idx % (1 << DIGIT_BITS)) * weight)
                                % MODULUS);
      end
      // Next power of 8 already reduced
      weight = (weight << DIGIT_BITS) % MODULUS;
    end
    return rom;
  endfunction

  // Entry v holds v * 2^shift mod MODULUS
  function automatic logic [FOLD_ENTRIES-1:0][RES_BITS-1:0] build_fold_rom(
    input int unsigned shift
  );
    logic [FOLD_ENTRIES-1:0][RES_BITS-1:0] rom;
    for (int unsigned v = 0; v < FOLD_ENTRIES; v++)
    begin
      rom[v] = RES_BITS'((v << shift) % MODULUS);
    end
    return rom;
  endfunction

  localparam logic [PP_WEIGHTS-1:0][PP_ENTRIES-1:0][RES_BITS-1:0] PP_ROM = build_pp_rom();
  // Weight 64 for sum bits 9..6
  localparam logic [FOLD_ENTRIES-1:0][RES_BITS-1:0] FOLD_MID_ROM = build_fold_rom(FOLD_LO);
  // Weight 1024 mod 997 = 27 for sum bits 13..10
  localparam logic [FOLD_ENTRIES-1:0][RES_BITS-1:0] FOLD_TOP_ROM = build_fold_rom(FOLD_HI);

endpackage

/* source/mod_exp_997_top.sv */
`timescale 1ns/1ps

module mod_exp_997_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              wr_en,
  input  logic [mod997_pkg::ADDR_BITS-1:0]  wr_addr,
  input  logic [mod997_pkg::RES_BITS-1:0]   wr_data,
  input  logic [mod997_pkg::ADDR_BITS-1:0]  rd_addr,
  output logic [mod997_pkg::RES_BITS-1:0]   rd_data,
  output logic                              done,
  output logic                              busy
);

  import mod997_pkg::*;

  // *************************************************************************
  // Internal links
  // *************************************************************************
  // Held job setup
  exp_cfg_t    cfg;
  // One-cycle pulse from a control write
  logic        start;
  // Engine state and result
  exp_status_t status;

  // Register port and sticky state
  exp_config_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .status  (status),
    .cfg     (cfg),
    .start   (start)
  );

  // Square-and-multiply sequencer
  mod_exp_engine u_engine (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .cfg    (cfg),
    .status (status)
  );

  // Engine flags straight out
  assign done = status.done;
  assign busy = status.busy;

endmodule

/* source/mod_exp_engine.sv */
`timescale 1ns/1ps

module mod_exp_engine (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  mod997_pkg::exp_cfg_t    cfg,
  output mod997_pkg::exp_status_t status
);

  import mod997_pkg::*;

  // Control state
  logic                 busy;
  logic                 done;
  logic [ITER_BITS-1:0] iter_cnt;

  // Running values of the right-to-left ladder
  residue_t             run_base;
  residue_t             run_result;
  logic [EXP_BITS-1:0]  exp_sr;

  // Multiplier outputs
  residue_t             base_sq;
  residue_t             result_mul;

  // Start only counts when idle
  logic                 accept;
  logic                 last_iter;

  assign accept    = start && !busy;
  assign last_iter = busy && (iter_cnt == ITER_BITS'(1));

  // *************************************************************************
  // Multipliers
  // *************************************************************************
  // Base squared every step
  mod_mult_997 u_square (
    .a       (run_base),
    .b       (run_base),
    .product (base_sq)
  );

  // Result times base when the exponent bit is set
  mod_mult_997 u_accum (
    .a       (run_result),
    .b       (run_base),
    .product (result_mul)
  );

  // *************************************************************************
  // Sequencer
  // *************************************************************************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      done     <= 1'b0;
      iter_cnt <= '0;
    end
    else
    begin
      // Done is a single-cycle pulse
      done <= 1'b0;
      if (accept)
      begin
        busy     <= 1'b1;
        iter_cnt <= ITER_BITS'(EXP_BITS);
      end
      else if (busy)
      begin
        iter_cnt <= iter_cnt - 1'b1;
        // Tenth step ends the job
        if (last_iter)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      // Snapshot the job
      run_result <= RES_BITS'(1);
      run_base   <= cfg.base;
      exp_sr     <= cfg.exponent;
    end
    else if (busy)
    begin
      if (exp_sr[0])
      begin
        run_result <= result_mul;
      end
      run_base <= base_sq;
      exp_sr   <= exp_sr >> 1;
    end
  end

  // Result is final in the done cycle
  assign status = '{busy: busy, done: done, result: run_result};

endmodule

/* source/mod_mult_997.sv */
`timescale 1ns/1ps

module mod_mult_997 (
  input  mod997_pkg::residue_t a,
  input  mod997_pkg::residue_t b,
  output mod997_pkg::residue_t product
);

  import mod997_pkg::*;

  // Radix-8 digit slices of each operand
  logic [NUM_DIGITS-1:0][DIGIT_BITS-1:0] a_dig;
  logic [NUM_DIGITS-1:0][DIGIT_BITS-1:0] b_dig;

  // Sixteen partial products, each already below MODULUS
  logic [NUM_DIGITS*NUM_DIGITS-1:0][RES_BITS-1:0] pp;

  // Raw sum of the folded partial products
  logic [SUM_BITS-1:0] pp_sum;

  // Second fold terms
  residue_t fold_mid;
  residue_t fold_top;

  // At most 63 + 960 + 405 so one subtraction is enough
  logic [RES_BITS:0] fold_sum;

  // *************************************************************************
  // Digit split
  // *************************************************************************
  // Zero extend to whole digits
  // Digit 3 only carries operand bit 9
  assign a_dig = (NUM_DIGITS * DIGIT_BITS)'(a);
  assign b_dig = (NUM_DIGITS * DIGIT_BITS)'(b);

  // *************************************************************************
  // Partial products
  // *************************************************************************
  // Digit pair (i, j) sits at weight 8^(i+j)
  // Table returns da * db * 8^(i+j) reduced
  always_comb
  begin
    for (int i = 0; i < NUM_DIGITS; i++)
    begin
      for (int j = 0; j < NUM_DIGITS; j++)
      begin
        pp[i * NUM_DIGITS + j] = PP_ROM[i + j][{a_dig[i], b_dig[j]}];
      end
    end
  end

  // Plain adder tree over all sixteen terms
  // 16 * 996 stays below 2^14
  always_comb
  begin
    pp_sum = '0;
    for (int n = 0; n < NUM_DIGITS * NUM_DIGITS; n++)
    begin
      pp_sum = pp_sum + SUM_BITS'(pp[n]);
    end
  end

  // *************************************************************************
  // Second fold
  // *************************************************************************
  // Bits 9..6 weigh 64
  assign fold_mid = FOLD_MID_ROM[pp_sum[FOLD_HI-1:FOLD_LO]];

  // Bits 13..10 weigh 1024 which is 27 mod 997
  assign fold_top = FOLD_TOP_ROM[pp_sum[SUM_BITS-1:FOLD_HI]];

  // Low six bits pass straight through
  assign fold_sum = (RES_BITS + 1)'(pp_sum[FOLD_LO-1:0])
                  + (RES_BITS + 1)'(fold_mid)
                  + (RES_BITS + 1)'(fold_top);

  // Final conditional subtraction
  always_comb
  begin
    if (fold_sum >= (RES_BITS + 1)'(MODULUS))
    begin
      product = RES_BITS'(fold_sum - (RES_BITS + 1)'(MODULUS));
    end
    else
    begin
      product = fold_sum[RES_BITS-1:0];
    end
  end

endmodule
